// ==== rtl/aluPkg.sv ====
// ALU opcode encoding for the execute cluster. Opcodes not listed here are reserved
// and produce result 0 with all flags unchanged.
package aluPkg;

	typedef logic [4:0] aluOp_t; // Five-bit ALU opcode.

	// Arithmetic group.
	localparam aluOp_t OP_MOV = 5'd0; // Pass operand B.
	localparam aluOp_t OP_ADD = 5'd1;
	localparam aluOp_t OP_ADC = 5'd2; // Add with carry in.
	localparam aluOp_t OP_SUB = 5'd3;
	localparam aluOp_t OP_SBB = 5'd4; // Subtract with borrow in.

	// Logic group, only Z is affected.
	localparam aluOp_t OP_AND = 5'd5;
	localparam aluOp_t OP_OR  = 5'd6;
	localparam aluOp_t OP_XOR = 5'd7;

	// Single-bit shifts act on operand B.
	localparam aluOp_t OP_ASR  = 5'd16;
	localparam aluOp_t OP_LSR  = 5'd17;
	localparam aluOp_t OP_LSL  = 5'd18;
	localparam aluOp_t OP_ROLC = 5'd19; // Rotate left through carry.
	localparam aluOp_t OP_RORC = 5'd20; // Rotate right through carry.

	// Flag set and clear, result is 0.
	localparam aluOp_t OP_CLC = 5'd22;
	localparam aluOp_t OP_SEC = 5'd23;
	localparam aluOp_t OP_CLZ = 5'd24;
	localparam aluOp_t OP_SEZ = 5'd25;
	localparam aluOp_t OP_CLS = 5'd26;
	localparam aluOp_t OP_SES = 5'd27;

endpackage

// ==== rtl/execPkg.sv ====
// Register file geometry shared by the queue, the pipeline and the register file.
package execPkg;

	localparam int REG_COUNT = 16; // General registers.

	localparam int REG_IDX_BITS = $clog2(REG_COUNT);

	typedef logic [REG_IDX_BITS-1:0] regIdx_t; // Register index.

endpackage

// ==== rtl/execIfs.sv ====
// Internal buses of the execute cluster. cmdIf pop is only legal while valid is high.
// aluIf flags change at the clock edge only when en is high.

interface cmdIf #(
	parameter int BITS = 16
);
	logic valid; // Head entry exists.
	aluPkg::aluOp_t op;
	execPkg::regIdx_t dst;
	execPkg::regIdx_t srcA;
	execPkg::regIdx_t srcB;
	logic useImm; // Immediate replaces operand B.
	logic [BITS-1:0] imm;
	logic pop; // Head consumed this cycle.

	modport producer (output valid, op, dst, srcA, srcB, useImm, imm, input pop);
	modport consumer (input valid, op, dst, srcA, srcB, useImm, imm, output pop);
endinterface

interface aluIf #(
	parameter int BITS = 16
);
	logic [BITS-1:0] a;
	logic [BITS-1:0] b;
	aluPkg::aluOp_t op;
	logic en; // Commit flags at this edge.
	logic [BITS-1:0] result; // Combinational.
	logic c;
	logic z;
	logic s;

	modport alu (input a, b, op, en, output result, c, z, s);
	modport pipe (output a, b, op, en, input result, c, z, s);
endinterface

// ==== rtl/cmdQueue.sv ====
// Command FIFO guarded by sender credits. The sender must never push into a full queue,
// and one credit is returned in every cycle that the head is popped.
module cmdQueue #(
	parameter int BITS = 16,
	parameter int QUEUE_DEPTH = 4
) (
	input  logic CLK,
	input  logic RSTb,
	input  logic cmdValid,
	input  aluPkg::aluOp_t cmdOp,
	input  execPkg::regIdx_t cmdDst,
	input  execPkg::regIdx_t cmdSrcA,
	input  execPkg::regIdx_t cmdSrcB,
	input  logic cmdUseImm,
	input  logic [BITS-1:0] cmdImm,
	output logic creditReturn,
	cmdIf.producer cmd
);
	localparam int PTR_BITS = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int CNT_BITS = $clog2(QUEUE_DEPTH + 1);

	aluPkg::aluOp_t opMem [QUEUE_DEPTH];
	execPkg::regIdx_t dstMem [QUEUE_DEPTH];
	execPkg::regIdx_t srcAMem [QUEUE_DEPTH];
	execPkg::regIdx_t srcBMem [QUEUE_DEPTH];
	logic useImmMem [QUEUE_DEPTH];
	logic [BITS-1:0] immMem [QUEUE_DEPTH];

	logic [PTR_BITS-1:0] wrPtr;
	logic [PTR_BITS-1:0] rdPtr;
	logic [CNT_BITS-1:0] count;

	always_ff @(posedge CLK) begin
		if (cmdValid) begin
			opMem[wrPtr] <= cmdOp;
			dstMem[wrPtr] <= cmdDst;
			srcAMem[wrPtr] <= cmdSrcA;
			srcBMem[wrPtr] <= cmdSrcB;
			useImmMem[wrPtr] <= cmdUseImm;
			immMem[wrPtr] <= cmdImm;
		end
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (cmdValid)
				wrPtr <= (wrPtr == PTR_BITS'(QUEUE_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
			if (cmd.pop)
				rdPtr <= (rdPtr == PTR_BITS'(QUEUE_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
			case ({cmdValid, cmd.pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // Push and pop together keep the level.
			endcase
		end
	end

	assign cmd.valid = (count != '0);
	assign cmd.op = opMem[rdPtr];
	assign cmd.dst = dstMem[rdPtr];
	assign cmd.srcA = srcAMem[rdPtr];
	assign cmd.srcB = srcBMem[rdPtr];
	assign cmd.useImm = useImmMem[rdPtr];
	assign cmd.imm = immMem[rdPtr];
	assign creditReturn = cmd.pop; // One credit per entry leaving.

	// A push into a full queue means the sender spent a credit it did not hold.
	noPushWhenFull: assert property (@(posedge CLK) disable iff (!RSTb)
		cmdValid |-> (count != CNT_BITS'(QUEUE_DEPTH)));

endmodule

// ==== rtl/regFile.sv ====
// Sixteen general registers, cleared on reset. Reads do not see a write of the same cycle;
// the pipeline forwards that case itself.
module regFile #(
	parameter int BITS = 16
) (
	input  logic CLK,
	input  logic RSTb,
	input  execPkg::regIdx_t rdAddrA,
	input  execPkg::regIdx_t rdAddrB,
	output logic [BITS-1:0] rdDataA,
	output logic [BITS-1:0] rdDataB,
	input  logic wrEn,
	input  execPkg::regIdx_t wrAddr,
	input  logic [BITS-1:0] wrData
);
	logic [BITS-1:0] regs [execPkg::REG_COUNT];

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			for (int i = 0; i < execPkg::REG_COUNT; i++)
				regs[i] <= '0;
		end else if (wrEn) begin
			regs[wrAddr] <= wrData;
		end
	end

	assign rdDataA = regs[rdAddrA]; // Combinational read ports.
	assign rdDataB = regs[rdAddrB];

endmodule

// ==== rtl/alu.sv ====
// ALU with registered carry, zero and sign flags. Shifts act on operand B only and
// reserved opcodes return 0 with the flags held.
module alu #(
	parameter int BITS = 16
) (
	input logic CLK,
	input logic RSTb,
	aluIf.alu alu
);
	logic cReg;
	logic zReg;
	logic sReg;
	logic cNext;
	logic zNext;
	logic sNext;
	logic [BITS-1:0] out;

	logic carryIn;
	logic borrowIn;
	logic [BITS:0] sumRes;
	logic [BITS:0] diffRes;

	assign carryIn = (alu.op == aluPkg::OP_ADC) & cReg; // Only adc consumes C.
	assign borrowIn = (alu.op == aluPkg::OP_SBB) & cReg; // Only sbb consumes C.
	assign sumRes = {1'b0, alu.a} + {1'b0, alu.b} + {{BITS{1'b0}}, carryIn};
	assign diffRes = {1'b0, alu.a} - {1'b0, alu.b} - {{BITS{1'b0}}, borrowIn}; // MSB is borrow.

	always_comb begin
		cNext = cReg; // Flags hold unless an op names them.
		zNext = zReg;
		sNext = sReg;
		out = '0;
		case (alu.op)
			aluPkg::OP_MOV: out = alu.b;
			aluPkg::OP_ADD, aluPkg::OP_ADC: begin
				out = sumRes[BITS-1:0];
				cNext = sumRes[BITS];
				zNext = (sumRes[BITS-1:0] == '0);
				sNext = sumRes[BITS-1];
			end
			aluPkg::OP_SUB, aluPkg::OP_SBB: begin
				out = diffRes[BITS-1:0];
				cNext = diffRes[BITS];
				zNext = (diffRes[BITS-1:0] == '0);
				sNext = diffRes[BITS-1];
			end
			aluPkg::OP_AND: begin
				out = alu.a & alu.b;
				zNext = ((alu.a & alu.b) == '0);
			end
			aluPkg::OP_OR: begin
				out = alu.a | alu.b;
				zNext = ((alu.a | alu.b) == '0);
			end
			aluPkg::OP_XOR: begin
				out = alu.a ^ alu.b;
				zNext = ((alu.a ^ alu.b) == '0);
			end
			aluPkg::OP_ASR: out = {alu.b[BITS-1], alu.b[BITS-1:1]};
			aluPkg::OP_LSR: out = {1'b0, alu.b[BITS-1:1]};
			aluPkg::OP_LSL: out = {alu.b[BITS-2:0], 1'b0};
			aluPkg::OP_ROLC: begin
				out = {alu.b[BITS-2:0], cReg};
				cNext = alu.a[BITS-1]; // New carry comes from A.
			end
			aluPkg::OP_RORC: begin
				out = {cReg, alu.b[BITS-1:1]};
				cNext = alu.a[0];
			end
			aluPkg::OP_CLC: cNext = 1'b0;
			aluPkg::OP_SEC: cNext = 1'b1;
			aluPkg::OP_CLZ: zNext = 1'b0;
			aluPkg::OP_SEZ: zNext = 1'b1;
			aluPkg::OP_CLS: sNext = 1'b0;
			aluPkg::OP_SES: sNext = 1'b1;
			default: out = '0; // Reserved.
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			cReg <= 1'b0;
			zReg <= 1'b0;
			sReg <= 1'b0;
		end else if (alu.en) begin
			cReg <= cNext;
			zReg <= zNext;
			sReg <= sNext;
		end
	end

	assign alu.result = out;
	assign alu.c = cReg;
	assign alu.z = zReg;
	assign alu.s = sReg;

	// Unknown operands from the pipeline must never leak into the flag state.
	flagsKnown: assert property (@(posedge CLK) disable iff (!RSTb)
		RSTb |=> !$isunknown({cReg, zReg, sReg}));

endmodule

// ==== rtl/execPipe.sv ====
// Two-stage pipeline: operand read in the pop cycle, execute and writeback in stage 2.
// It never stalls, so every valid head is popped at once.
module execPipe #(
	parameter int BITS = 16
) (
	input  logic CLK,
	input  logic RSTb,
	cmdIf.consumer cmd,
	aluIf.pipe alu,
	output execPkg::regIdx_t rdAddrA,
	output execPkg::regIdx_t rdAddrB,
	input  logic [BITS-1:0] rdDataA,
	input  logic [BITS-1:0] rdDataB,
	output logic wrEn,
	output execPkg::regIdx_t wrAddr,
	output logic [BITS-1:0] wrData,
	output logic resultValid,
	output execPkg::regIdx_t resultReg,
	output logic [BITS-1:0] resultData
);
	logic s2Valid;
	aluPkg::aluOp_t s2Op;
	execPkg::regIdx_t s2Dst;
	logic [BITS-1:0] s2A;
	logic [BITS-1:0] s2B;
	logic [BITS-1:0] opA;
	logic [BITS-1:0] regB;

	assign cmd.pop = cmd.valid;
	assign rdAddrA = cmd.srcA;
	assign rdAddrB = cmd.srcB;

	// Forward the result that stage 2 writes in this very cycle.
	assign opA = (wrEn && wrAddr == cmd.srcA) ? wrData : rdDataA;
	assign regB = (wrEn && wrAddr == cmd.srcB) ? wrData : rdDataB;

	always_ff @(posedge CLK) begin
		if (!RSTb)
			s2Valid <= 1'b0;
		else
			s2Valid <= cmd.pop;
	end

	always_ff @(posedge CLK) begin
		if (cmd.pop) begin
			s2Op <= cmd.op;
			s2Dst <= cmd.dst;
			s2A <= opA;
			s2B <= cmd.useImm ? cmd.imm : regB; // Immediate replaces B.
		end
	end

	assign alu.a = s2A;
	assign alu.b = s2B;
	assign alu.op = s2Op;
	assign alu.en = s2Valid;

	assign wrEn = s2Valid; // Every command writes back, flag ops included.
	assign wrAddr = s2Dst;
	assign wrData = alu.result;

	always_ff @(posedge CLK) begin
		if (!RSTb)
			resultValid <= 1'b0;
		else
			resultValid <= wrEn;
	end

	always_ff @(posedge CLK) begin
		resultReg <= wrAddr;
		resultData <= wrData;
	end

	// A popped head must be a fully written queue entry.
	popNeedsValid: assert property (@(posedge CLK) disable iff (!RSTb)
		cmd.pop |-> cmd.valid && !$isunknown({cmd.op, cmd.dst, cmd.srcA, cmd.srcB, cmd.useImm}));

endmodule

// ==== rtl/execTop.sv ====
// Execute cluster top. The sender starts with QUEUE_DEPTH credits and gets one back
// per creditReturn pulse; results have no back-pressure.
module execTop #(
	parameter int BITS = 16,
	parameter int QUEUE_DEPTH = 4
) (
	input  logic CLK,
	input  logic RSTb,
	input  logic cmdValid,
	input  aluPkg::aluOp_t cmdOp,
	input  execPkg::regIdx_t cmdDst,
	input  execPkg::regIdx_t cmdSrcA,
	input  execPkg::regIdx_t cmdSrcB,
	input  logic cmdUseImm,
	input  logic [BITS-1:0] cmdImm,
	output logic creditReturn,
	output logic resultValid,
	output execPkg::regIdx_t resultReg,
	output logic [BITS-1:0] resultData,
	output logic flagC,
	output logic flagZ,
	output logic flagS
);
	execPkg::regIdx_t rdAddrA;
	execPkg::regIdx_t rdAddrB;
	logic [BITS-1:0] rdDataA;
	logic [BITS-1:0] rdDataB;
	logic wrEn;
	execPkg::regIdx_t wrAddr;
	logic [BITS-1:0] wrData;

	cmdIf #(.BITS(BITS)) cmdBus ();
	aluIf #(.BITS(BITS)) aluBus ();

	cmdQueue #(.BITS(BITS), .QUEUE_DEPTH(QUEUE_DEPTH)) queue (
		.CLK, .RSTb, .cmdValid, .cmdOp, .cmdDst, .cmdSrcA, .cmdSrcB,
		.cmdUseImm, .cmdImm, .creditReturn, .cmd(cmdBus.producer));

	execPipe #(.BITS(BITS)) pipe (
		.CLK, .RSTb, .cmd(cmdBus.consumer), .alu(aluBus.pipe),
		.rdAddrA, .rdAddrB, .rdDataA, .rdDataB, .wrEn, .wrAddr, .wrData,
		.resultValid, .resultReg, .resultData);

	regFile #(.BITS(BITS)) regs (
		.CLK, .RSTb, .rdAddrA, .rdAddrB, .rdDataA, .rdDataB, .wrEn, .wrAddr, .wrData);

	alu #(.BITS(BITS)) aluInst (.CLK, .RSTb, .alu(aluBus.alu));

	assign flagC = aluBus.c; // Flags line up with resultValid.
	assign flagZ = aluBus.z;
	assign flagS = aluBus.s;

endmodule

// ==== bench/execChecker.sv ====
// Compares every result with the next expected row in command order and counts credits.
// Outputs are sampled at the rising edge, where the flags already belong to the result.
module execChecker #(
	parameter int BITS = 16
) (
	input logic CLK,
	input logic RSTb,
	input logic creditReturn,
	input logic resultValid,
	input execPkg::regIdx_t resultReg,
	input logic [BITS-1:0] resultData,
	input logic flagC,
	input logic flagZ,
	input logic flagS
);
	execPkg::regIdx_t expReg [$];
	logic [BITS-1:0] expData [$];
	logic [2:0] expFlags [$]; // C, Z, S.
	int seenCount = 0;
	int failCount = 0;
	int creditCount = 0;

	task automatic expectRow(input execPkg::regIdx_t dst, input logic [BITS-1:0] data,
			input logic [2:0] flags);
		expReg.push_back(dst);
		expData.push_back(data);
		expFlags.push_back(flags);
	endtask

	// Prints a Mismatch line and returns 0 when the values differ.
	function automatic bit sameValue(input string name, input logic [BITS-1:0] got,
			input logic [BITS-1:0] want);
		if (got === want)
			return 1'b1;
		$display("Mismatch at %0t: %s got %h, expected %h", $time, name, got, want);
		return 1'b0;
	endfunction

	always @(posedge CLK) begin : sampleOutputs
		logic [2:0] flags;
		bit ok;
		if (RSTb && creditReturn === 1'b1)
			creditCount <= creditCount + 1;
		if (RSTb && resultValid === 1'b1) begin
			if (expReg.size() == 0) begin
				$display("Error at %0t: a result for r%0d came with no command pending",
					$time, resultReg);
				failCount <= failCount + 1;
			end else begin
				flags = expFlags.pop_front();
				ok = sameValue("resultReg", resultReg, expReg.pop_front());
				ok = sameValue("resultData", resultData, expData.pop_front()) && ok;
				ok = sameValue("flagC", flagC, flags[2]) && ok;
				ok = sameValue("flagZ", flagZ, flags[1]) && ok;
				ok = sameValue("flagS", flagS, flags[0]) && ok;
				$display("Test %0d %s: r%0d = %h, C %b Z %b S %b", seenCount + 1,
					ok ? "passed" : "failed", resultReg, resultData, flagC, flagZ, flagS);
				seenCount <= seenCount + 1;
				if (!ok)
					failCount <= failCount + 1;
			end
		end
	end

endmodule

// ==== bench/execTb.sv ====
// Sends the command table into execTop, never spending more credits than it holds.
// The closing burst chains random adds through r15, so each one needs forwarding.
module execTb;
	localparam int BITS = 16;
	localparam int QUEUE_DEPTH = 4;
	localparam int TIMEOUT = 100; // Cycles allowed for any single wait.
	localparam int CMD_BITS = $bits(aluPkg::aluOp_t) + 3 * $bits(execPkg::regIdx_t) + 1 + BITS;

	logic CLK = 1'b0;
	logic RSTb = 1'b0;
	logic cmdValid = 1'b0;
	aluPkg::aluOp_t cmdOp = '0;
	execPkg::regIdx_t cmdDst = '0;
	execPkg::regIdx_t cmdSrcA = '0;
	execPkg::regIdx_t cmdSrcB = '0;
	logic cmdUseImm = 1'b0;
	logic [BITS-1:0] cmdImm = '0;
	logic creditReturn;
	logic resultValid;
	execPkg::regIdx_t resultReg;
	logic [BITS-1:0] resultData;
	logic flagC;
	logic flagZ;
	logic flagS;

	logic [CMD_BITS-1:0] cmds [$]; // Op, dst, srcA, srcB, useImm, imm.
	integer seed = 32'h7d00_61da;
	logic [BITS-1:0] rnd;
	logic [BITS:0] sum; // Running sum with its carry out.
	int credits = QUEUE_DEPTH;
	int sent = 0;
	int waited = 0;
	bit timedOut = 1'b0;

	execTop #(.BITS(BITS), .QUEUE_DEPTH(QUEUE_DEPTH)) UUT (.*);
	execChecker #(.BITS(BITS)) checks (.*);

	always #10 CLK = ~CLK;

	// Queues one command and hands its expected result to the checker.
	task automatic addRow(input aluPkg::aluOp_t op, input execPkg::regIdx_t dst,
			input execPkg::regIdx_t srcA, input execPkg::regIdx_t srcB,
			input logic useImm, input logic [BITS-1:0] imm,
			input logic [BITS-1:0] data, input logic [2:0] flags);
		cmds.push_back({op, dst, srcA, srcB, useImm, imm});
		checks.expectRow(dst, data, flags);
	endtask

	initial begin
		// Expected flags are given as C, Z, S.
		addRow(aluPkg::OP_MOV, 4'd1, 4'd0, 4'd0, 1'b1, 16'hFFFF, 16'hFFFF, 3'b000);
		addRow(aluPkg::OP_MOV, 4'd2, 4'd0, 4'd0, 1'b1, 16'h0001, 16'h0001, 3'b000);
		addRow(aluPkg::OP_MOV, 4'd3, 4'd0, 4'd1, 1'b0, 16'h0000, 16'hFFFF, 3'b000); // Copy.
		addRow(aluPkg::OP_ADD, 4'd4, 4'd3, 4'd2, 1'b0, 16'h0000, 16'h0000, 3'b110);
		addRow(aluPkg::OP_ADC, 4'd5, 4'd2, 4'd0, 1'b1, 16'h0010, 16'h0012, 3'b000);
		addRow(aluPkg::OP_SUB, 4'd6, 4'd0, 4'd2, 1'b0, 16'h0000, 16'hFFFF, 3'b101);
		addRow(aluPkg::OP_SBB, 4'd6, 4'd2, 4'd0, 1'b1, 16'h0000, 16'h0000, 3'b010);
		addRow(aluPkg::OP_MOV, 4'd7, 4'd0, 4'd0, 1'b1, 16'h8001, 16'h8001, 3'b010);
		addRow(aluPkg::OP_SUB, 4'd9, 4'd2, 4'd7, 1'b0, 16'h0000, 16'h8000, 3'b101);
		addRow(aluPkg::OP_AND, 4'd10, 4'd7, 4'd0, 1'b1, 16'h00FE, 16'h0000, 3'b111);
		addRow(aluPkg::OP_OR, 4'd11, 4'd7, 4'd2, 1'b0, 16'h0000, 16'h8001, 3'b101);
		addRow(aluPkg::OP_XOR, 4'd12, 4'd7, 4'd0, 1'b1, 16'h8001, 16'h0000, 3'b111);
		addRow(aluPkg::OP_ASR, 4'd13, 4'd0, 4'd0, 1'b1, 16'h8004, 16'hC002, 3'b111);
		addRow(aluPkg::OP_LSR, 4'd13, 4'd0, 4'd0, 1'b1, 16'h8004, 16'h4002, 3'b111);
		addRow(aluPkg::OP_LSL, 4'd13, 4'd0, 4'd0, 1'b1, 16'h8004, 16'h0008, 3'b111);
		addRow(aluPkg::OP_ROLC, 4'd14, 4'd2, 4'd0, 1'b1, 16'hC000, 16'h8001, 3'b011);
		addRow(aluPkg::OP_RORC, 4'd14, 4'd7, 4'd0, 1'b1, 16'h0002, 16'h0001, 3'b111);
		addRow(aluPkg::OP_CLC, 4'd15, 4'd0, 4'd0, 1'b0, 16'h0000, 16'h0000, 3'b011);
		addRow(aluPkg::OP_CLZ, 4'd15, 4'd0, 4'd0, 1'b0, 16'h0000, 16'h0000, 3'b001);
		addRow(aluPkg::OP_CLS, 4'd15, 4'd0, 4'd0, 1'b0, 16'h0000, 16'h0000, 3'b000);
		addRow(aluPkg::OP_SEC, 4'd15, 4'd0, 4'd0, 1'b0, 16'h0000, 16'h0000, 3'b100);
		addRow(5'd9, 4'd15, 4'd1, 4'd7, 1'b0, 16'h0000, 16'h0000, 3'b100); // Reserved.
		addRow(aluPkg::OP_SEZ, 4'd15, 4'd0, 4'd0, 1'b0, 16'h0000, 16'h0000, 3'b110);
		addRow(aluPkg::OP_SES, 4'd15, 4'd0, 4'd0, 1'b0, 16'h0000, 16'h0000, 3'b111);
		sum = {1'b0, BITS'($random(seed))};
		addRow(aluPkg::OP_MOV, 4'd15, 4'd0, 4'd0, 1'b1, sum[BITS-1:0], sum[BITS-1:0], 3'b111);
		for (int k = 0; k < 3; k++) begin
			rnd = BITS'($random(seed));
			sum = {1'b0, sum[BITS-1:0]} + {1'b0, rnd};
			addRow(aluPkg::OP_ADD, 4'd15, 4'd15, 4'd0, 1'b1, rnd, sum[BITS-1:0],
				{sum[BITS], ~|sum[BITS-1:0], sum[BITS-1]});
		end
		repeat (4) @(posedge CLK);
		RSTb <= 1'b1;
		// A credit returned in the last cycle can be spent at this edge.
		while (sent < cmds.size() && !timedOut) begin
			@(posedge CLK);
			if (creditReturn)
				credits++;
			cmdValid <= 1'b0;
			if (credits > 0) begin
				{cmdOp, cmdDst, cmdSrcA, cmdSrcB, cmdUseImm, cmdImm} <= cmds[sent];
				cmdValid <= 1'b1;
				credits--;
				sent++;
				waited = 0;
			end else begin
				waited++;
				if (waited > TIMEOUT) begin
					$display("Timeout: no credit came back to send command %0d", sent + 1);
					timedOut = 1'b1;
				end
			end
		end
		waited = 0;
		while (!timedOut && (checks.seenCount < cmds.size() || credits < QUEUE_DEPTH)) begin
			@(posedge CLK);
			if (creditReturn)
				credits++;
			cmdValid <= 1'b0;
			waited++;
			if (waited > TIMEOUT) begin
				$display("Timeout: only %0d of %0d results arrived, %0d credits held",
					checks.seenCount, cmds.size(), credits);
				timedOut = 1'b1;
			end
		end
		if (checks.creditCount != sent)
			$display("Mismatch at %0t: creditReturn pulses got %0d, expected %0d",
				$time, checks.creditCount, sent);
		$display("%0d results checked, %0d failed, %0d credits returned for %0d commands",
			checks.seenCount, checks.failCount, checks.creditCount, sent);
		if (timedOut || checks.failCount != 0 || checks.creditCount != sent)
			$display("Something failed");
		else
			$display("Everything OK");
		$finish;
	end

endmodule

// ==== cpuExec.f ====
rtl/aluPkg.sv
rtl/execPkg.sv
rtl/execIfs.sv
rtl/cmdQueue.sv
rtl/regFile.sv
rtl/alu.sv
rtl/execPipe.sv
rtl/execTop.sv
bench/execChecker.sv
bench/execTb.sv
